// ==== design/recovery_types_pkg.sv ====
`default_nettype none

package recovery_types_pkg;

  // One received recovery command
  typedef struct packed {
    logic [7:0]  cmd;
    logic [15:0] len;
    logic        is_rd;
    logic        error;
  } rx_cmd_t;

  // One queued payload word, nbytes counts valid bytes from 1 to 4
  typedef struct packed {
    logic [31:0] data;
    logic [2:0]  nbytes;
  } rx_word_t;

  // Receiver FSM states
  typedef enum logic [3:0] {
    Idle    = 4'h0,
    RxCmd   = 4'h1,
    RxLenL  = 4'h2,
    RxLenH  = 4'h3,
    RxData  = 4'h4,
    RxPec   = 4'h5,
    CmdIsRd = 4'h6,
    Cmd     = 4'h7,
    Busy    = 4'h8
  } rx_state_e;

endpackage

`default_nettype wire

// ==== design/recovery_cfg_pkg.sv ====
`default_nettype none

package recovery_cfg_pkg;

  // Payload word queue depth
  localparam int unsigned WordFifoDepth = 8;

  // SMBus style PEC, CRC-8 with x^8 + x^2 + x + 1
  localparam logic [7:0] PecPoly = 8'h07;

  // PEC error counter saturates at all ones
  localparam int unsigned ErrCountWidth = 8;

endpackage

`default_nettype wire

// ==== design/pec_crc8.sv ====
`timescale 1ns/1ps
`default_nettype none

module pec_crc8 (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       clear_i,
  input  wire logic       update_i,
  input  wire logic [7:0] byte_i,
  output logic      [7:0] crc_o
);

  // MSB first, one full byte per call
  function automatic logic [7:0] crc8_step(logic [7:0] crc, logic [7:0] data);
    logic [7:0] c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      if (c[7]) begin
        c = {c[6:0], 1'b0} ^ recovery_cfg_pkg::PecPoly;
      end else begin
        c = {c[6:0], 1'b0};
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_o <= 8'h00;
    end else if (clear_i) begin
      crc_o <= 8'h00;
    end else if (update_i) begin
      crc_o <= crc8_step(crc_o, byte_i);
    end
  end

endmodule

`default_nettype wire

// ==== design/byte_word_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_word_packer (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       push_i,
  input  wire logic [7:0] byte_i,
  input  wire logic       flush_i,
  input  wire logic       drop_i,
  output logic            word_valid_o,
  output recovery_types_pkg::rx_word_t word_o
);

  logic [1:0]  count_q;
  logic [31:0] data_q;
  logic        emit_full;
  logic        emit_part;

  // Fourth byte completes a word, flush emits whatever is pending
  assign emit_full = push_i && !drop_i && (count_q == 2'd3);
  assign emit_part = flush_i && !drop_i && (count_q != 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q      <= 2'd0;
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= emit_full || emit_part;
      if (drop_i || emit_part) begin
        count_q <= 2'd0;
      end else if (push_i) begin
        count_q <= count_q + 2'd1;
      end
    end
  end

  // Little-endian fill, first byte of a word zeroes the upper bytes
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      if (count_q == 2'd0) begin
        data_q <= {24'd0, byte_i};
      end else begin
        data_q[{count_q, 3'b000} +: 8] <= byte_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (emit_full) begin
      word_o.data   <= {byte_i, data_q[23:0]};
      word_o.nbytes <= 3'd4;
    end else if (emit_part) begin
      word_o.data   <= data_q;
      word_o.nbytes <= {1'b0, count_q};
    end
  end

endmodule

`default_nettype wire

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type         T     = logic [7:0],
  parameter int unsigned Depth = 4
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic push_i,
  input  wire T     data_i,
  input  wire logic pop_i,
  output T          data_o,
  output logic      valid_o,
  output logic      full_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  T                mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  function automatic logic [PtrW-1:0] ptr_next(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign do_pop  = pop_i && (count_q != '0);
  assign do_push = push_i && ((count_q != CntW'(Depth)) || do_pop);

  assign data_o  = mem_q[rd_ptr_q];
  assign valid_o = (count_q != '0);
  // Also counts a word landing this cycle so the producer stops in time
  assign full_o  = (count_q == CntW'(Depth)) ||
                   (push_i && (count_q == CntW'(Depth - 1)));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_next(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

`default_nettype wire

// ==== design/recovery_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module recovery_receiver (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic [7:0] rx_byte_i,
  input  wire logic       rx_valid_i,
  output logic            rx_ready_o,
  input  wire logic       bus_start_i,
  input  wire logic       bus_stop_i,
  input  wire logic       fifo_full_i,
  input  wire logic [7:0] crc_value_i,
  output logic            crc_clear_o,
  output logic            crc_update_o,
  output logic            pack_push_o,
  output logic      [7:0] pack_byte_o,
  output logic            pack_flush_o,
  output logic            pack_drop_o,
  output logic            cmd_load_o,
  output recovery_types_pkg::rx_cmd_t cmd_o,
  input  wire logic       cmd_done_i
);

  recovery_types_pkg::rx_state_e state_q, state_d;

  logic        accept;
  logic        in_frame;
  logic [15:0] dcnt_q;
  logic [7:0]  cmd_q;
  logic [7:0]  len_l_q;
  logic [7:0]  len_h_q;
  logic [7:0]  pec_recv_q;
  logic [7:0]  pec_calc_q;
  logic        is_rd_q;
  // Delays cmd_load until the padded word has reached the FIFO
  logic [1:0]  load_pipe_q;

  assign accept   = rx_valid_i && rx_ready_o;
  assign in_frame = (state_q inside {recovery_types_pkg::RxCmd, recovery_types_pkg::RxLenL,
                                     recovery_types_pkg::RxLenH, recovery_types_pkg::RxData,
                                     recovery_types_pkg::RxPec});

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      recovery_types_pkg::Idle: begin
        if (bus_start_i) state_d = recovery_types_pkg::RxCmd;
      end
      recovery_types_pkg::RxCmd: begin
        if (accept) state_d = recovery_types_pkg::RxLenL;
        else if (bus_stop_i) state_d = recovery_types_pkg::Idle;
      end
      recovery_types_pkg::RxLenL: begin
        if (accept) state_d = recovery_types_pkg::RxLenH;
        else if (bus_stop_i) state_d = recovery_types_pkg::Idle;
      end
      recovery_types_pkg::RxLenH: begin
        // Zero length skips straight to the PEC byte
        if (accept) begin
          state_d = ({rx_byte_i, len_l_q} == 16'd0) ? recovery_types_pkg::RxPec
                                                    : recovery_types_pkg::RxData;
        end else if (bus_start_i) begin
          state_d = recovery_types_pkg::CmdIsRd;
        end else if (bus_stop_i) begin
          state_d = recovery_types_pkg::Idle;
        end
      end
      recovery_types_pkg::RxData: begin
        if (accept && (dcnt_q == 16'd1)) state_d = recovery_types_pkg::RxPec;
        else if (!accept && bus_stop_i) state_d = recovery_types_pkg::Idle;
      end
      recovery_types_pkg::RxPec: begin
        if (accept) state_d = recovery_types_pkg::Cmd;
        else if (bus_stop_i) state_d = recovery_types_pkg::Idle;
      end
      recovery_types_pkg::CmdIsRd: state_d = recovery_types_pkg::Cmd;
      recovery_types_pkg::Cmd:     state_d = recovery_types_pkg::Busy;
      recovery_types_pkg::Busy: begin
        if (cmd_done_i) state_d = recovery_types_pkg::Idle;
      end
      default: state_d = recovery_types_pkg::Idle;
    endcase
  end

  // Payload bytes wait while the word queue has no room
  always_comb begin
    unique case (state_q)
      recovery_types_pkg::RxCmd,
      recovery_types_pkg::RxLenL,
      recovery_types_pkg::RxLenH,
      recovery_types_pkg::RxPec:  rx_ready_o = 1'b1;
      recovery_types_pkg::RxData: rx_ready_o = !fifo_full_i;
      default:                    rx_ready_o = 1'b0;
    endcase
  end

  assign crc_clear_o  = (state_q == recovery_types_pkg::Idle) && bus_start_i;
  assign crc_update_o = accept;
  assign pack_push_o  = accept && (state_q == recovery_types_pkg::RxData);
  assign pack_byte_o  = rx_byte_i;
  assign pack_flush_o = (state_q == recovery_types_pkg::Cmd) && (len_l_q[1:0] != 2'b00);
  assign pack_drop_o  = in_frame && !accept && bus_stop_i;
  assign cmd_load_o   = load_pipe_q[1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= recovery_types_pkg::Idle;
      is_rd_q     <= 1'b0;
      load_pipe_q <= 2'b00;
    end else begin
      state_q     <= state_d;
      load_pipe_q <= {load_pipe_q[0], state_q == recovery_types_pkg::Cmd};
      if (state_q == recovery_types_pkg::CmdIsRd) is_rd_q <= 1'b1;
      else if (state_q == recovery_types_pkg::Idle) is_rd_q <= 1'b0;
    end
  end

  // Header capture, byte counter and PEC snapshot
  always_ff @(posedge clk_i) begin
    unique case (state_q)
      recovery_types_pkg::RxCmd: begin
        if (accept) cmd_q <= rx_byte_i;
      end
      recovery_types_pkg::RxLenL: begin
        if (accept) begin
          len_l_q     <= rx_byte_i;
          dcnt_q[7:0] <= rx_byte_i;
          // CRC of the command byte alone, used if this turns out a read
          pec_calc_q  <= crc_value_i;
        end
      end
      recovery_types_pkg::RxLenH: begin
        if (accept) begin
          len_h_q      <= rx_byte_i;
          dcnt_q[15:8] <= rx_byte_i;
        end
      end
      recovery_types_pkg::RxData: begin
        if (accept) dcnt_q <= dcnt_q - 16'd1;
      end
      recovery_types_pkg::RxPec: begin
        if (accept) begin
          pec_recv_q <= rx_byte_i;
          pec_calc_q <= crc_value_i;
        end
      end
      recovery_types_pkg::CmdIsRd: begin
        // Byte after the command was the PEC
        pec_recv_q <= len_l_q;
        len_l_q    <= 8'd0;
        len_h_q    <= 8'd0;
      end
      default: begin
      end
    endcase
  end

  assign cmd_o = '{cmd:   cmd_q,
                   len:   {len_h_q, len_l_q},
                   is_rd: is_rd_q,
                   error: (pec_calc_q != pec_recv_q)};

endmodule

`default_nettype wire

// ==== design/recovery_cmd_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module recovery_cmd_csr (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         load_i,
  input  wire recovery_types_pkg::rx_cmd_t  cmd_i,
  input  wire logic                         ack_i,
  output recovery_types_pkg::rx_cmd_t       cmd_o,
  output logic                              cmd_valid_o,
  output logic                              done_o,
  output logic [recovery_cfg_pkg::ErrCountWidth-1:0] err_count_o
);

  logic ack_ok;

  // Acks outside a valid command are ignored
  assign ack_ok = ack_i && cmd_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_o <= 1'b0;
      done_o      <= 1'b0;
      err_count_o <= '0;
    end else begin
      done_o <= ack_ok;
      if (load_i) begin
        cmd_valid_o <= 1'b1;
      end else if (ack_ok) begin
        cmd_valid_o <= 1'b0;
      end
      // Saturating PEC failure count
      if (load_i && cmd_i.error && (err_count_o != '1)) begin
        err_count_o <= err_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) cmd_o <= cmd_i;
  end

endmodule

`default_nettype wire

// ==== design/recovery_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module recovery_rx_top (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic [7:0]                   rx_byte_i,
  input  wire logic                         rx_valid_i,
  output logic                              rx_ready_o,
  input  wire logic                         bus_start_i,
  input  wire logic                         bus_stop_i,
  output recovery_types_pkg::rx_word_t      word_o,
  output logic                              word_valid_o,
  input  wire logic                         word_pop_i,
  output recovery_types_pkg::rx_cmd_t       cmd_o,
  output logic                              cmd_valid_o,
  input  wire logic                         cmd_ack_i,
  output logic [recovery_cfg_pkg::ErrCountWidth-1:0] pec_err_count_o
);

  logic                         fifo_full;
  logic [7:0]                   crc_value;
  logic                         crc_clear;
  logic                         crc_update;
  logic                         pack_push;
  logic [7:0]                   pack_byte;
  logic                         pack_flush;
  logic                         pack_drop;
  logic                         pack_valid;
  recovery_types_pkg::rx_word_t pack_word;
  logic                         cmd_load;
  recovery_types_pkg::rx_cmd_t  rx_cmd;
  logic                         cmd_done;

  recovery_receiver u_receiver (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_byte_i    (rx_byte_i),
    .rx_valid_i   (rx_valid_i),
    .rx_ready_o   (rx_ready_o),
    .bus_start_i  (bus_start_i),
    .bus_stop_i   (bus_stop_i),
    .fifo_full_i  (fifo_full),
    .crc_value_i  (crc_value),
    .crc_clear_o  (crc_clear),
    .crc_update_o (crc_update),
    .pack_push_o  (pack_push),
    .pack_byte_o  (pack_byte),
    .pack_flush_o (pack_flush),
    .pack_drop_o  (pack_drop),
    .cmd_load_o   (cmd_load),
    .cmd_o        (rx_cmd),
    .cmd_done_i   (cmd_done)
  );

  pec_crc8 u_pec (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (crc_clear),
    .update_i (crc_update),
    .byte_i   (rx_byte_i),
    .crc_o    (crc_value)
  );

  byte_word_packer u_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (pack_push),
    .byte_i       (pack_byte),
    .flush_i      (pack_flush),
    .drop_i       (pack_drop),
    .word_valid_o (pack_valid),
    .word_o       (pack_word)
  );

  // Payload words waiting for software
  sync_fifo #(
    .T     (recovery_types_pkg::rx_word_t),
    .Depth (recovery_cfg_pkg::WordFifoDepth)
  ) u_word_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (pack_valid),
    .data_i  (pack_word),
    .pop_i   (word_pop_i),
    .data_o  (word_o),
    .valid_o (word_valid_o),
    .full_o  (fifo_full)
  );

  recovery_cmd_csr u_cmd_csr (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (cmd_load),
    .cmd_i       (rx_cmd),
    .ack_i       (cmd_ack_i),
    .cmd_o       (cmd_o),
    .cmd_valid_o (cmd_valid_o),
    .done_o      (cmd_done),
    .err_count_o (pec_err_count_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_recovery_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_recovery_rx;

  localparam int NumFrames     = 40;
  localparam int FrameCycles   = 30;
  localparam int ClkPeriod     = 10;
  localparam int WatchdogNs    = NumFrames * FrameCycles * ClkPeriod * 4;
  localparam int ByteTimeout   = 100;
  localparam int RecordTimeout = 20;
  localparam int StallRelease  = 12;
  localparam int PauseFrame    = 15;
  localparam int KindHdr       = 0;
  localparam int KindData      = 1;
  localparam int KindPec       = 2;
  // PEC byte to cmd_valid_o, and the extra CmdIsRd step for a read
  localparam int WriteLatency  = 3;
  localparam int ReadLatency   = 4;

  logic                                        clk_i = 1'b0;
  logic                                        rst_ni;
  logic [7:0]                                  rx_byte_i;
  logic                                        rx_valid_i;
  logic                                        rx_ready_o;
  logic                                        bus_start_i;
  logic                                        bus_stop_i;
  recovery_types_pkg::rx_word_t                word_o;
  logic                                        word_valid_o;
  logic                                        word_pop_i;
  recovery_types_pkg::rx_cmd_t                 cmd_o;
  logic                                        cmd_valid_o;
  logic                                        cmd_ack_i;
  logic [recovery_cfg_pkg::ErrCountWidth-1:0]  pec_err_count_o;

  // Reference model state
  recovery_types_pkg::rx_word_t exp_q[$];
  recovery_types_pkg::rx_word_t head_word;
  logic [31:0] cur_data;
  int          cur_n;
  logic [7:0]  crc_run;
  int          exp_err_count;
  int          errors;
  int          records;
  int          words_checked;
  logic        pause;
  logic        stall_seen;

  recovery_rx_top u_recovery_rx_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rx_byte_i       (rx_byte_i),
    .rx_valid_i      (rx_valid_i),
    .rx_ready_o      (rx_ready_o),
    .bus_start_i     (bus_start_i),
    .bus_stop_i      (bus_stop_i),
    .word_o          (word_o),
    .word_valid_o    (word_valid_o),
    .word_pop_i      (word_pop_i),
    .cmd_o           (cmd_o),
    .cmd_valid_o     (cmd_valid_o),
    .cmd_ack_i       (cmd_ack_i),
    .pec_err_count_o (pec_err_count_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Bit-serial CRC-8, x^8 + x^2 + x + 1, zero start
  function automatic logic [7:0] pec_next(logic [7:0] crc, logic [7:0] data);
    logic [7:0] c;
    logic       fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[7] ^ data[i];
      c  = {c[6:0], 1'b0};
      if (fb) c = c ^ 8'h07;
    end
    return c;
  endfunction

  task automatic note_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("ERROR t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic push_word();
    recovery_types_pkg::rx_word_t w;
    w.data   = cur_data;
    w.nbytes = 3'(cur_n);
    exp_q.push_back(w);
    cur_data = '0;
    cur_n    = 0;
  endtask

  // Random pops, head word checked against the model
  always @(negedge clk_i) begin
    word_pop_i = 1'b0;
    if (rst_ni && !pause && word_valid_o && ($urandom_range(2) == 0)) begin
      word_pop_i = 1'b1;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected word 0x%0h in the queue at t=%0t", word_o.data, $time);
      end else begin
        head_word = exp_q.pop_front();
        words_checked++;
        if (word_o.data !== head_word.data)
          note_mismatch("word_o.data", word_o.data, head_word.data);
        if (word_o.nbytes !== head_word.nbytes)
          note_mismatch("word_o.nbytes", word_o.nbytes, head_word.nbytes);
      end
    end
  end

  task automatic gap(int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic send_byte(logic [7:0] b, int kind);
    int waited;
    waited = 0;
    @(negedge clk_i);
    rx_byte_i  = b;
    rx_valid_i = 1'b1;
    while (!rx_ready_o && waited < ByteTimeout) begin
      // Queue held full long enough, let software drain it again
      if (kind == KindData && pause && waited >= StallRelease) begin
        stall_seen = 1'b1;
        pause <= 1'b0;
      end
      waited++;
      @(negedge clk_i);
    end
    if (!rx_ready_o) begin
      errors++;
      $display("Byte 0x%0h was not accepted within %0d cycles", b, ByteTimeout);
      rx_valid_i = 1'b0;
      return;
    end
    @(posedge clk_i);
    if (kind == KindData) begin
      if (exp_q.size() >= recovery_cfg_pkg::WordFifoDepth) begin
        errors++;
        $display("Payload byte accepted at t=%0t while the word queue was full", $time);
      end
      cur_data[cur_n*8 +: 8] = b;
      cur_n++;
      if (cur_n == 4) push_word();
    end else if (kind == KindPec && cur_n != 0) begin
      push_word();
    end
    crc_run = pec_next(crc_run, b);
    @(negedge clk_i);
    rx_valid_i = 1'b0;
    // Frame closed, no more bytes taken
    if (kind == KindPec && rx_ready_o !== 1'b0) note_mismatch("rx_ready_o", rx_ready_o, 0);
  endtask

  task automatic pulse_start(bit from_idle);
    @(negedge clk_i);
    bus_start_i = 1'b1;
    if (from_idle) crc_run = 8'h00;
    @(negedge clk_i);
    bus_start_i = 1'b0;
    if (from_idle && rx_ready_o !== 1'b1) note_mismatch("rx_ready_o", rx_ready_o, 1);
  endtask

  // Waits for the record, checks it, then acknowledges
  task automatic expect_record(int exp_lat, recovery_types_pkg::rx_cmd_t exp);
    int n;
    n = 0;
    while (!cmd_valid_o && n < RecordTimeout) begin
      @(negedge clk_i);
      n++;
    end
    if (!cmd_valid_o) begin
      errors++;
      $display("No command record within %0d cycles at t=%0t", RecordTimeout, $time);
      return;
    end
    records++;
    if (n != exp_lat) note_mismatch("cmd_valid_o latency", n, exp_lat);
    if (cmd_o.cmd !== exp.cmd) note_mismatch("cmd_o.cmd", cmd_o.cmd, exp.cmd);
    if (cmd_o.len !== exp.len) note_mismatch("cmd_o.len", cmd_o.len, exp.len);
    if (cmd_o.is_rd !== exp.is_rd) note_mismatch("cmd_o.is_rd", cmd_o.is_rd, exp.is_rd);
    if (cmd_o.error !== exp.error) note_mismatch("cmd_o.error", cmd_o.error, exp.error);
    if (pec_err_count_o !== 8'(exp_err_count))
      note_mismatch("pec_err_count_o", pec_err_count_o, exp_err_count);
    gap($urandom_range(2));
    cmd_ack_i = 1'b1;
    @(negedge clk_i);
    cmd_ack_i = 1'b0;
    if (cmd_valid_o !== 1'b0) note_mismatch("cmd_valid_o", cmd_valid_o, 0);
    // Receiver returns to Idle one cycle after done
    gap(2);
  endtask

  task automatic run_write(int len, bit bad_pec);
    recovery_types_pkg::rx_cmd_t exp;
    logic [7:0] pec;
    exp.cmd   = 8'($urandom);
    exp.len   = 16'(len);
    exp.is_rd = 1'b0;
    exp.error = bad_pec;
    pulse_start(1'b1);
    send_byte(exp.cmd, KindHdr);
    send_byte(8'(len), KindHdr);
    send_byte(8'h00, KindHdr);
    for (int i = 0; i < len; i++) begin
      gap($urandom_range(1));
      send_byte(8'($urandom), KindData);
    end
    pec = bad_pec ? (crc_run ^ (8'h01 << $urandom_range(7))) : crc_run;
    if (bad_pec) exp_err_count++;
    send_byte(pec, KindPec);
    expect_record(WriteLatency, exp);
  endtask

  task automatic run_read(bit bad_pec);
    recovery_types_pkg::rx_cmd_t exp;
    logic [7:0] pec;
    exp.cmd   = 8'($urandom);
    exp.len   = 16'd0;
    exp.is_rd = 1'b1;
    exp.error = bad_pec;
    pulse_start(1'b1);
    send_byte(exp.cmd, KindHdr);
    // PEC covers the command byte only
    pec = bad_pec ? (crc_run ^ (8'h01 << $urandom_range(7))) : crc_run;
    if (bad_pec) exp_err_count++;
    send_byte(pec, KindHdr);
    gap($urandom_range(2));
    pulse_start(1'b0);
    expect_record(ReadLatency, exp);
  endtask

  task automatic run_abort();
    int  len;
    int  k;
    bit  seen;
    len  = 1 + $urandom_range(12);
    k    = $urandom_range(len);
    seen = 1'b0;
    pulse_start(1'b1);
    send_byte(8'($urandom), KindHdr);
    send_byte(8'(len), KindHdr);
    send_byte(8'h00, KindHdr);
    for (int i = 0; i < k; i++) send_byte(8'($urandom), KindData);
    @(negedge clk_i);
    bus_stop_i = 1'b1;
    @(negedge clk_i);
    bus_stop_i = 1'b0;
    // Partial word is lost, full words stay queued
    cur_data = '0;
    cur_n    = 0;
    repeat (6) begin
      @(negedge clk_i);
      if (cmd_valid_o && !seen) begin
        seen = 1'b1;
        errors++;
        $display("Aborted frame produced a command record at t=%0t", $time);
      end
    end
  endtask

  initial begin
    #(WatchdogNs);
    $display("Timeout: the run did not complete within %0d ns", WatchdogNs);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int unsigned r;
    int          n;
    bit          bad;
    rst_ni        = 1'b0;
    rx_byte_i     = 8'h00;
    rx_valid_i    = 1'b0;
    bus_start_i   = 1'b0;
    bus_stop_i    = 1'b0;
    word_pop_i    = 1'b0;
    cmd_ack_i     = 1'b0;
    cur_data      = '0;
    cur_n         = 0;
    crc_run       = 8'h00;
    exp_err_count = 0;
    errors        = 0;
    records       = 0;
    words_checked = 0;
    pause         = 1'b0;
    stall_seen    = 1'b0;
    r = $urandom(32'hccdd_0998);

    repeat (2) @(negedge clk_i);
    if (rx_ready_o !== 1'b0) note_mismatch("rx_ready_o", rx_ready_o, 0);
    if (word_valid_o !== 1'b0) note_mismatch("word_valid_o", word_valid_o, 0);
    if (cmd_valid_o !== 1'b0) note_mismatch("cmd_valid_o", cmd_valid_o, 0);
    if (pec_err_count_o !== '0) note_mismatch("pec_err_count_o", pec_err_count_o, 0);
    rst_ni = 1'b1;
    gap(2);

    for (int f = 0; f < NumFrames; f++) begin
      // Hold pops and send long writes until the queue backs up
      if (f == PauseFrame) pause <= 1'b1;
      bad = ($urandom_range(99) < 20);
      r   = $urandom_range(99);
      if (f == PauseFrame || pause) run_write(13, bad);
      else if (r < 60) run_write($urandom_range(13), bad);
      else if (r < 85) run_read(bad);
      else run_abort();
      gap($urandom_range(2));
    end

    pause <= 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < 200) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected words never left the queue", exp_q.size());
    end
    gap(4);
    if (word_valid_o) begin
      errors++;
      $display("Queue still holds a word after all expected words were popped");
    end
    if (!stall_seen) begin
      errors++;
      $display("The byte stream was never stalled by a full word queue");
    end

    $display("Summary: %0d frames, %0d records, %0d words checked, %0d errors",
             NumFrames, records, words_checked, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/recovery_types_pkg.sv
design/recovery_cfg_pkg.sv
design/pec_crc8.sv
design/byte_word_packer.sv
design/sync_fifo.sv
design/recovery_receiver.sv
design/recovery_cmd_csr.sv
design/recovery_rx_top.sv
testbench/tb_recovery_rx.sv
